// File: hdl/nocPkg.sv
package nocPkg;

  // Flit kinds as carried on inFlitId and linkFlitId
  localparam logic [2:0] flitKindIdle   = 3'd0;
  localparam logic [2:0] flitKindHeader = 3'd1; // Low data bits hold the window length
  localparam logic [2:0] flitKindBody   = 3'd2;
  localparam logic [2:0] flitKindTail   = 3'd3;

  // Number of input ports competing for this output channel
  localparam int portCount = 5;

  // Port indices, also the value driven on linkSrc
  localparam logic [2:0] portLocal = 3'd0;
  localparam logic [2:0] portNorth = 3'd1;
  localparam logic [2:0] portEast  = 3'd2;
  localparam logic [2:0] portWest  = 3'd3;
  localparam logic [2:0] portSouth = 3'd4;

  // One-hot arbiter states
  // Bit 0 means no grant, bit i+1 means port i owns the link
  localparam logic [5:0] grantIdle  = 6'b000001;
  localparam logic [5:0] grantLocal = 6'b000010;
  localparam logic [5:0] grantNorth = 6'b000100;
  localparam logic [5:0] grantEast  = 6'b001000;
  localparam logic [5:0] grantWest  = 6'b010000;
  localparam logic [5:0] grantSouth = 6'b100000;

endpackage

// File: hdl/portBuffer.sv
module portBuffer #(
  parameter int flitDataWidth = 16,
  parameter int bufferDepth = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  logic [2:0] inFlitId,
  input  logic [flitDataWidth-1:0] inData,
  input  logic pop,
  output logic req,
  output logic full,
  output logic [2:0] headFlitId,
  output logic [flitDataWidth-1:0] headData
);

  localparam int ptrWidth = $clog2(bufferDepth);

  logic [2:0] flitIdMem [bufferDepth];
  logic [flitDataWidth-1:0] dataMem [bufferDepth];
  logic [ptrWidth-1:0] readPtr;
  logic [ptrWidth-1:0] writePtr;
  logic [ptrWidth:0] count;
  logic doWrite;
  logic doPop;

  assign req = (count != '0);
  assign full = (count == (ptrWidth + 1)'(bufferDepth));

  assign doWrite = inValid && !full;
  assign doPop = pop && req;

  // Head flit straight from storage so the arbiter sees it in the same cycle
  assign headFlitId = flitIdMem[readPtr];
  assign headData = dataMem[readPtr];

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      flitIdMem[writePtr] <= inFlitId;
      dataMem[writePtr] <= inData;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      readPtr <= '0;
      writePtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        writePtr <= writePtr + 1'b1;
      if (doPop)
        readPtr <= readPtr + 1'b1;
      if (doWrite && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doWrite)
        count <= count - 1'b1;
    end
  end

  // The sender has to watch full before strobing
  noWriteWhenFull: assert property (
    @(posedge clk) disable iff (rst) inValid |-> !full
  );

  // The output link may only pop a port that shows a request
  noPopWhenEmpty: assert property (
    @(posedge clk) disable iff (rst) pop |-> req
  );

endmodule

// File: hdl/grantTimer.sv
module grantTimer #(
  parameter int flitDataWidth = 16,
  parameter int lengthWidth = 12
) (
  input  logic clk,
  input  logic rst,
  input  logic [2:0] headFlitId,
  input  logic [flitDataWidth-1:0] headData,
  input  logic runTimer,
  output logic timesUp
);

  logic [lengthWidth-1:0] windowLength;
  logic [lengthWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      windowLength <= '0;
      count <= '0;
    end
    else
    begin
      // A header sitting at the head sets the window of the next grant
      if (headFlitId == nocPkg::flitKindHeader)
        windowLength <= headData[lengthWidth-1:0];
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0; // Back to zero whenever the port is not holding
    end
  end

  assign timesUp = (count == windowLength);

endmodule

// File: hdl/linkArbiter.sv
module linkArbiter #(
  parameter int flitDataWidth = 16,
  parameter int lengthWidth = 12
) (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::portCount-1:0] req,
  input  logic [2:0] headFlitId [nocPkg::portCount],
  input  logic [flitDataWidth-1:0] headData [nocPkg::portCount],
  output logic [5:0] grantState
);

  logic [5:0] nextState;
  logic [nocPkg::portCount-1:0] runTimer;
  logic [nocPkg::portCount-1:0] timesUp;
  logic holding;
  logic [2:0] holdIdx;
  logic stay;

  for (genvar p = 0; p < nocPkg::portCount; p++)
  begin : gTimer
    grantTimer #(
      .flitDataWidth(flitDataWidth),
      .lengthWidth(lengthWidth)
    ) timer (
      .clk(clk),
      .rst(rst),
      .headFlitId(headFlitId[p]),
      .headData(headData[p]),
      .runTimer(runTimer[p]),
      .timesUp(timesUp[p])
    );
  end

  // Which port, if any, owns the link right now
  always_comb
  begin
    holding = 1'b0;
    holdIdx = '0;
    for (int i = 0; i < nocPkg::portCount; i++)
    begin
      if (grantState[i + 1])
      begin
        holding = 1'b1;
        holdIdx = 3'(i);
      end
    end
  end

  assign stay = holding && req[holdIdx] && !timesUp[holdIdx];

  always_comb
  begin
    int start;
    int cand;
    logic found;

    runTimer = '0;
    nextState = nocPkg::grantIdle;
    found = 1'b0;
    cand = 0;
    // From idle the search starts at Local, otherwise just past the holder
    start = holding ? int'(holdIdx) + 1 : 0;

    if (stay)
    begin
      runTimer[holdIdx] = 1'b1; // Counts only the cycles after the first one
      nextState = grantState;
    end
    else
    begin
      for (int k = 0; k < nocPkg::portCount; k++)
      begin
        cand = (start + k) % nocPkg::portCount;
        if (!found && req[cand] && !(holding && cand == int'(holdIdx)))
        begin
          found = 1'b1;
          nextState = '0;
          nextState[cand + 1] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grantState <= nocPkg::grantIdle;
    else
      grantState <= nextState;
  end

  grantOneHot: assert property (
    @(posedge clk) disable iff (rst) $onehot(grantState)
  );

  // Leaving idle must land on a port that was asking for the link
  idleGrantsRequester: assert property (
    @(posedge clk) disable iff (rst)
    (grantState == nocPkg::grantIdle) |=>
      ((grantState[nocPkg::portCount:1] & ~$past(req)) == '0)
  );

endmodule

// File: hdl/outputLink.sv
module outputLink #(
  parameter int flitDataWidth = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic [5:0] grantState,
  input  logic [nocPkg::portCount-1:0] req,
  input  logic [2:0] headFlitId [nocPkg::portCount],
  input  logic [flitDataWidth-1:0] headData [nocPkg::portCount],
  output logic [nocPkg::portCount-1:0] pop,
  output logic linkValid,
  output logic [2:0] linkFlitId,
  output logic [flitDataWidth-1:0] linkData,
  output logic [2:0] linkSrc
);

  logic [2:0] srcIdx;

  always_comb
  begin
    case (grantState)
      nocPkg::grantLocal: srcIdx = nocPkg::portLocal;
      nocPkg::grantNorth: srcIdx = nocPkg::portNorth;
      nocPkg::grantEast:  srcIdx = nocPkg::portEast;
      nocPkg::grantWest:  srcIdx = nocPkg::portWest;
      nocPkg::grantSouth: srcIdx = nocPkg::portSouth;
      default:            srcIdx = nocPkg::portLocal;
    endcase
  end

  // Idle bit sits below the port bits, so an idle arbiter pops nothing
  assign pop = grantState[nocPkg::portCount:1] & req;

  always_ff @(posedge clk)
  begin
    if (rst)
      linkValid <= 1'b0;
    else
      linkValid <= |pop;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      linkFlitId <= headFlitId[srcIdx];
      linkData <= headData[srcIdx];
      linkSrc <= srcIdx;
    end
  end

  // Relies on the arbiter never granting two ports at once
  singlePop: assert property (
    @(posedge clk) disable iff (rst) $onehot0(pop)
  );

endmodule

// File: hdl/routerOutputTop.sv
module routerOutputTop #(
  parameter int flitDataWidth = 16,
  parameter int bufferDepth = 8,
  parameter int lengthWidth = 12
) (
  input  logic clk,
  input  logic rst,
  input  logic [nocPkg::portCount-1:0] inValid,
  input  logic [2:0] inFlitId [nocPkg::portCount],
  input  logic [flitDataWidth-1:0] inData [nocPkg::portCount],
  output logic [nocPkg::portCount-1:0] full,
  output logic linkValid,
  output logic [2:0] linkFlitId,
  output logic [flitDataWidth-1:0] linkData,
  output logic [2:0] linkSrc
);

  logic [nocPkg::portCount-1:0] req;
  logic [nocPkg::portCount-1:0] pop;
  logic [2:0] headFlitId [nocPkg::portCount];
  logic [flitDataWidth-1:0] headData [nocPkg::portCount];
  logic [5:0] grantState;

  // Port order is Local, North, East, West, South
  for (genvar p = 0; p < nocPkg::portCount; p++)
  begin : gPort
    portBuffer #(
      .flitDataWidth(flitDataWidth),
      .bufferDepth(bufferDepth)
    ) buffer (
      .clk(clk),
      .rst(rst),
      .inValid(inValid[p]),
      .inFlitId(inFlitId[p]),
      .inData(inData[p]),
      .pop(pop[p]),
      .req(req[p]),
      .full(full[p]),
      .headFlitId(headFlitId[p]),
      .headData(headData[p])
    );
  end

  linkArbiter #(
    .flitDataWidth(flitDataWidth),
    .lengthWidth(lengthWidth)
  ) arbiter (
    .clk(clk),
    .rst(rst),
    .req(req),
    .headFlitId(headFlitId),
    .headData(headData),
    .grantState(grantState)
  );

  outputLink #(
    .flitDataWidth(flitDataWidth)
  ) link (
    .clk(clk),
    .rst(rst),
    .grantState(grantState),
    .req(req),
    .headFlitId(headFlitId),
    .headData(headData),
    .pop(pop),
    .linkValid(linkValid),
    .linkFlitId(linkFlitId),
    .linkData(linkData),
    .linkSrc(linkSrc)
  );

endmodule

// File: sim/routerOutputTb.sv
module routerOutputTb;

  localparam int flitDataWidth = 16;
  localparam int bufferDepth = 8;
  localparam int lengthWidth = 12;
  localparam int testCount = 6;
  localparam int flitWidth = flitDataWidth + 3; // Kind on top of the data

  logic clk = 1'b0;
  logic rst;
  logic [nocPkg::portCount-1:0] inValid;
  logic [2:0] inFlitId [nocPkg::portCount];
  logic [flitDataWidth-1:0] inData [nocPkg::portCount];
  logic [nocPkg::portCount-1:0] full;
  logic linkValid;
  logic [2:0] linkFlitId;
  logic [flitDataWidth-1:0] linkData;
  logic [2:0] linkSrc;

  // One packet per port in the start mask, columns run L, N, E, W, S
  string testName [testCount] = '{"reset idle", "east single", "all five", "window split",
    "full level", "idle rearm"};
  logic [4:0] startMask [testCount] = '{5'b00000, 5'b00100, 5'b11111, 5'b10010, 5'b01001,
    5'b10000};
  int lenField [testCount][5] = '{'{0, 0, 0, 0, 0}, '{0, 0, 5, 0, 0}, '{3, 3, 3, 3, 3},
    '{0, 2, 0, 0, 3}, '{15, 0, 0, 1, 0}, '{0, 0, 0, 0, 1}};
  int flitCount [testCount][5] = '{'{0, 0, 0, 0, 0}, '{0, 0, 6, 0, 0}, '{8, 4, 4, 4, 4},
    '{0, 7, 0, 0, 3}, '{12, 0, 0, 8, 0}, '{0, 0, 0, 0, 4}};
  // Source of each grant window in the order it reaches the link
  string expOrder [testCount] = '{"", "E", "LNEWSL", "NSNN", "LWWWW", "SS"};
  logic [4:0] expFull [testCount] = '{5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b01000,
    5'b00000};

  logic [flitWidth-1:0] pending [nocPkg::portCount][$];
  logic [flitWidth-1:0] modelQ [nocPkg::portCount][$];
  int modelGrant; // Negative while the arbiter is idle
  logic [lengthWidth-1:0] modelLen [nocPkg::portCount];
  logic [lengthWidth-1:0] modelCount [nocPkg::portCount];
  logic expValid;
  logic [2:0] expSrc;
  logic [2:0] expKind;
  logic [flitDataWidth-1:0] expData;
  logic [31:0] lcgState = 32'd84;
  int errorCount = 0;
  string obsOrder;
  logic prevValid;
  logic [2:0] prevSrc;
  logic [4:0] fullSeen;

  routerOutputTop #(
    .flitDataWidth(flitDataWidth),
    .bufferDepth(bufferDepth),
    .lengthWidth(lengthWidth)
  ) dut (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inFlitId(inFlitId),
    .inData(inData),
    .full(full),
    .linkValid(linkValid),
    .linkFlitId(linkFlitId),
    .linkData(linkData),
    .linkSrc(linkSrc)
  );

  always #10 clk = ~clk;

  function automatic logic [flitDataWidth-1:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[31:16];
  endfunction

  function automatic string portName(logic [2:0] idx);
    case (idx)
      nocPkg::portLocal: return "L";
      nocPkg::portNorth: return "N";
      nocPkg::portEast:  return "E";
      nocPkg::portWest:  return "W";
      nocPkg::portSouth: return "S";
      default:           return "?";
    endcase
  endfunction

  task automatic loadRow(int t);
    logic [2:0] kind;
    logic [flitDataWidth-1:0] data;
    for (int p = 0; p < nocPkg::portCount; p++)
    begin
      for (int i = 0; startMask[t][p] && i < flitCount[t][p]; i++)
      begin
        kind = (i == 0) ? nocPkg::flitKindHeader :
          (i == flitCount[t][p] - 1) ? nocPkg::flitKindTail : nocPkg::flitKindBody;
        data = (i == 0) ? flitDataWidth'(lenField[t][p]) : lcgNext();
        pending[p].push_back({kind, data});
      end
    end
  endtask

  // One flit per port per cycle, held back while the model says the queue is full
  task automatic driveInputs();
    for (int p = 0; p < nocPkg::portCount; p++)
    begin
      if (pending[p].size() > 0 && modelQ[p].size() < bufferDepth)
      begin
        inValid[p] = 1'b1;
        {inFlitId[p], inData[p]} = pending[p].pop_front();
      end
      else
        inValid[p] = 1'b0;
    end
  endtask

  task automatic advanceModel();
    int holder;
    int next;
    int start;
    int cand;
    logic stay;
    holder = modelGrant;
    stay = 1'b0;
    if (holder >= 0)
      stay = (modelQ[holder].size() > 0) && (modelCount[holder] != modelLen[holder]);
    for (int p = 0; p < nocPkg::portCount; p++)
    begin
      // A header at the head sets that port's window for the next edge
      if (modelQ[p].size() > 0 && modelQ[p][0][flitWidth-1:flitDataWidth] == 3'd1)
        modelLen[p] = modelQ[p][0][lengthWidth-1:0];
      if (stay && p == holder)
        modelCount[p] = modelCount[p] + lengthWidth'(1);
      else
        modelCount[p] = '0;
    end
    expValid = 1'b0;
    if (holder >= 0 && modelQ[holder].size() > 0)
    begin
      expValid = 1'b1;
      expSrc = 3'(holder);
      {expKind, expData} = modelQ[holder].pop_front();
    end
    next = -1;
    start = (holder >= 0) ? holder + 1 : 0;
    for (int k = 0; k < nocPkg::portCount; k++)
    begin
      cand = (start + k) % nocPkg::portCount;
      if (!stay && next < 0 && cand != holder && modelQ[cand].size() > 0)
        next = cand;
    end
    modelGrant = stay ? holder : next;
    for (int p = 0; p < nocPkg::portCount; p++)
    begin
      if (inValid[p])
        modelQ[p].push_back({inFlitId[p], inData[p]});
    end
  endtask

  task automatic checkOutputs();
    logic fullExp;
    for (int p = 0; p < nocPkg::portCount; p++)
    begin
      fullExp = (modelQ[p].size() == bufferDepth);
      assert (full[p] == fullExp)
      else
      begin
        $display("[FAIL] full[%0d] got %h expected %h", p, full[p], fullExp);
        errorCount++;
      end
    end
    fullSeen = fullSeen | full;
    if (expValid && !linkValid)
    begin
      $display("A flit of kind %0d from port %s never showed up on the link",
        expKind, portName(expSrc));
      errorCount++;
    end
    else if (expValid)
    begin
      assert (linkSrc == expSrc)
      else
      begin
        $display("[FAIL] linkSrc got %h expected %h", linkSrc, expSrc);
        errorCount++;
      end
      assert (linkFlitId == expKind)
      else
      begin
        $display("[FAIL] linkFlitId got %h expected %h", linkFlitId, expKind);
        errorCount++;
      end
      assert (linkData == expData)
      else
      begin
        $display("[FAIL] linkData got %h expected %h", linkData, expData);
        errorCount++;
      end
    end
    else
    begin
      assert (!linkValid)
      else
      begin
        $display("The link carried a flit from port %s that nobody sent", portName(linkSrc));
        errorCount++;
      end
    end
    if (linkValid && (!prevValid || linkSrc != prevSrc))
      obsOrder = {obsOrder, portName(linkSrc)}; // A new grant window starts here
    prevValid = linkValid;
    prevSrc = linkSrc;
  endtask

  task automatic runCycle();
    driveInputs();
    advanceModel();
    @(posedge clk);
    #2;
    checkOutputs();
  endtask

  function automatic logic modelDrained();
    logic drained;
    drained = !expValid && modelGrant < 0;
    for (int p = 0; p < nocPkg::portCount; p++)
      drained = drained && pending[p].size() == 0 && modelQ[p].size() == 0;
    return drained;
  endfunction

  initial
  begin
    int passCount;
    int failCount;
    int errBefore;
    int cycles;
    passCount = 0;
    failCount = 0;
    rst = 1'b1;
    inValid = '0;
    for (int p = 0; p < nocPkg::portCount; p++)
    begin
      inFlitId[p] = '0;
      inData[p] = '0;
      modelLen[p] = '0;
      modelCount[p] = '0;
    end
    modelGrant = -1;
    expValid = 1'b0;
    prevValid = 1'b0;
    prevSrc = '0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int t = 0; t < testCount; t++)
    begin
      errBefore = errorCount;
      obsOrder = "";
      fullSeen = '0;
      cycles = 0;
      loadRow(t);
      do
      begin
        runCycle();
        cycles++;
      end
      while (!(modelDrained() && cycles >= 10));
      assert (obsOrder == expOrder[t])
      else
      begin
        $display("Grant windows came in order \"%s\" instead of \"%s\"", obsOrder, expOrder[t]);
        errorCount++;
      end
      assert (fullSeen == expFull[t])
      else
      begin
        $display("[FAIL] full seen %h expected %h", fullSeen, expFull[t]);
        errorCount++;
      end
      if (errorCount == errBefore)
      begin
        passCount++;
        $display("test %s: ok after %0d cycles", testName[t], cycles);
      end
      else
      begin
        failCount++;
        $display("test %s: %0d errors", testName[t], errorCount - errBefore);
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", testCount, passCount, failCount,
      errorCount);
    if (failCount == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // Four cycles per flit plus a fixed margin for reset and idle gaps
  initial
  begin
    int limit;
    limit = 200;
    for (int t = 0; t < testCount; t++)
      for (int p = 0; p < nocPkg::portCount; p++)
        limit += 4 * flitCount[t][p];
    repeat (limit) @(posedge clk);
    $display("Watchdog ran out after %0d cycles with tests still running", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: src.f
hdl/nocPkg.sv
hdl/portBuffer.sv
hdl/grantTimer.sv
hdl/linkArbiter.sv
hdl/outputLink.sv
hdl/routerOutputTop.sv
sim/routerOutputTb.sv

// File: Makefile
# Verilator build of the router output channel testbench

TOP = routerOutputTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
